// ==== rtl/ext_mem_pkg.sv ====
// Shared sizes, queue counter types, request and response structs, error codes
package ext_mem_pkg;

  // --------------------
  // Sizes
  // --------------------
  localparam int data_width = 32;
  localparam int tag_width = 2;
  localparam int ld_count = 2;
  localparam int st_count = 2;
  localparam int mem_depth = 256;
  localparam int addr_width = 8;
  localparam int lsq_depth = 4;
  localparam int deadlock_timeout = 32;

  // Derived widths for the store queues and the deadlock timer
  localparam int lsq_ptr_width = $clog2(lsq_depth);
  localparam int lsq_cnt_width = $clog2(lsq_depth + 1);
  localparam int dl_cnt_width = $clog2(deadlock_timeout + 1);

  // --------------------
  // Basic types
  // --------------------
  typedef logic [addr_width-1:0] mem_addr_t;
  typedef logic [data_width-1:0] mem_data_t;
  typedef logic [tag_width-1:0] mem_tag_t;

  typedef logic [lsq_ptr_width-1:0] lsq_ptr_t;
  typedef logic [lsq_cnt_width-1:0] lsq_cnt_t;
  typedef logic [dl_cnt_width-1:0] dl_cnt_t;

  // Load request and store address
  typedef struct packed {
    mem_tag_t  tag;
    mem_addr_t addr;
  } tag_req_t;

  // Store data and load response
  typedef struct packed {
    mem_tag_t  tag;
    mem_data_t data;
  } tag_data_t;

  // Runtime error codes
  typedef enum logic [15:0] {
    err_none           = 16'h0000,
    err_tag_oob        = 16'h0101,
    err_store_deadlock = 16'h0102
  } mem_err_e;

endpackage

// ==== rtl/mem_array.sv ====
// Behavioral external memory with two asynchronous read ports and one write port
`timescale 1ns/1ps

module mem_array import ext_mem_pkg::*; (
  input  logic                      clk,
  input  mem_addr_t [ld_count-1:0]  rd_addr,
  output mem_data_t [ld_count-1:0]  rd_data,
  input  logic                      wr_en,
  input  mem_addr_t                 wr_addr,
  input  mem_data_t                 wr_data
);

  mem_data_t mem [mem_depth];

  // --------------------
  // Read ports
  // --------------------
  for (genvar i = 0; i < ld_count; i++) begin : g_rd
    // Combinational read, same cycle as the request
    assign rd_data[i] = mem[rd_addr[i]];
  end

  // --------------------
  // Write port
  // --------------------
  // Committed stores land on the pop edge
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

// ==== rtl/load_ports.sv ====
// Load data path with tagged responses, load-done tag select and tag range check
`timescale 1ns/1ps

module load_ports import ext_mem_pkg::*; (
  input  logic [ld_count-1:0]       ld_req_valid,
  input  tag_req_t [ld_count-1:0]   ld_req,
  output logic [ld_count-1:0]       ld_req_ready,
  output logic [ld_count-1:0]       ld_resp_valid,
  output tag_data_t [ld_count-1:0]  ld_resp,
  input  logic [ld_count-1:0]       ld_resp_ready,
  output logic                      ld_done_valid,
  output mem_tag_t                  ld_done_tag,
  input  logic                      ld_done_ready,
  output mem_addr_t [ld_count-1:0]  rd_addr,
  input  mem_data_t [ld_count-1:0]  rd_data,
  output logic                      ld_tag_oob
);

  // --------------------
  // Per-port data path
  // --------------------
  for (genvar i = 0; i < ld_count; i++) begin : g_port
    assign rd_addr[i] = ld_req[i].addr;
    assign ld_resp_valid[i] = ld_req_valid[i];
    assign ld_resp[i].tag = ld_req[i].tag;
    assign ld_resp[i].data = rd_data[i];
    // A load needs both its response and the shared done port
    assign ld_req_ready[i] = ld_resp_ready[i] && ld_done_ready;
  end

  assign ld_done_valid = |ld_req_valid;

  // --------------------
  // Done tag and range check
  // --------------------
  always_comb begin
    ld_done_tag = '0;
    ld_tag_oob = 1'b0;
    // Ascending scan, so the highest valid port wins
    for (int i = 0; i < ld_count; i++) begin
      if (ld_req_valid[i]) begin
        ld_done_tag = ld_req[i].tag;
        if (int'(ld_req[i].tag) >= ld_count) begin
          ld_tag_oob = 1'b1;
        end
      end
    end
  end

endmodule

// ==== rtl/store_tag_router.sv ====
// Store address and data steering into per-tag queues, ready and store tag check
`timescale 1ns/1ps

module store_tag_router import ext_mem_pkg::*; (
  input  logic [st_count-1:0]       st_addr_valid,
  input  tag_req_t [st_count-1:0]   st_addr,
  output logic [st_count-1:0]       st_addr_ready,
  input  logic [st_count-1:0]       st_data_valid,
  input  tag_data_t [st_count-1:0]  st_data,
  output logic [st_count-1:0]       st_data_ready,
  input  logic [st_count-1:0]       addr_full,
  input  logic [st_count-1:0]       data_full,
  output logic [st_count-1:0]       addr_enq,
  output mem_addr_t [st_count-1:0]  addr_enq_val,
  output logic [st_count-1:0]       data_enq,
  output mem_data_t [st_count-1:0]  data_enq_val,
  output logic                      st_tag_oob
);

  // Out-of-range tags fall back to queue 0
  function automatic int target_tag(mem_tag_t tag);
    if (int'(tag) >= st_count) begin
      return 0;
    end
    return int'(tag);
  endfunction

  // --------------------
  // Routing
  // --------------------
  always_comb begin
    int a_tag;
    int d_tag;
    addr_enq = '0;
    addr_enq_val = '0;
    data_enq = '0;
    data_enq_val = '0;
    st_tag_oob = 1'b0;
    for (int p = 0; p < st_count; p++) begin
      a_tag = target_tag(st_addr[p].tag);
      d_tag = target_tag(st_data[p].tag);

      // Address side
      st_addr_ready[p] = !addr_full[a_tag];
      if (st_addr_valid[p] && st_addr_ready[p]) begin
        addr_enq[a_tag] = 1'b1;
        addr_enq_val[a_tag] = st_addr[p].addr;
      end

      // Data side
      st_data_ready[p] = !data_full[d_tag];
      if (st_data_valid[p] && st_data_ready[p]) begin
        data_enq[d_tag] = 1'b1;
        data_enq_val[d_tag] = st_data[p].data;
      end

      // Range check uses the raw tag, before the clamp
      if (st_addr_valid[p] && int'(st_addr[p].tag) >= st_count) begin
        st_tag_oob = 1'b1;
      end
      if (st_data_valid[p] && int'(st_data[p].tag) >= st_count) begin
        st_tag_oob = 1'b1;
      end
    end
  end

endmodule

// ==== rtl/store_pair_queue.sv ====
// Per-tag store address and data queues with pairing status and deadlock timer
`timescale 1ns/1ps

module store_pair_queue import ext_mem_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       addr_enq,
  input  mem_addr_t  addr_enq_val,
  input  logic       data_enq,
  input  mem_data_t  data_enq_val,
  input  logic       pop,
  output logic       addr_full,
  output logic       data_full,
  output logic       can_pair,
  output mem_addr_t  head_addr,
  output mem_data_t  head_data,
  output logic       deadlock_hit
);

  mem_addr_t addr_q [lsq_depth];
  mem_data_t data_q [lsq_depth];

  lsq_ptr_t addr_wr_ptr;
  lsq_ptr_t addr_rd_ptr;
  lsq_ptr_t data_wr_ptr;
  lsq_ptr_t data_rd_ptr;
  lsq_cnt_t addr_cnt;
  lsq_cnt_t data_cnt;
  dl_cnt_t  dl_cnt;

  logic addr_empty;
  logic data_empty;

  // Wrap at lsq_depth, which need not be a power of two
  function automatic lsq_ptr_t next_ptr(lsq_ptr_t ptr);
    return (ptr == lsq_ptr_t'(lsq_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // --------------------
  // Status
  // --------------------
  assign addr_empty = (addr_cnt == '0);
  assign data_empty = (data_cnt == '0);
  assign addr_full = (addr_cnt == lsq_cnt_t'(lsq_depth));
  assign data_full = (data_cnt == lsq_cnt_t'(lsq_depth));
  assign can_pair = !addr_empty && !data_empty;
  assign head_addr = addr_q[addr_rd_ptr];
  assign head_data = data_q[data_rd_ptr];

  // --------------------
  // Queue storage
  // --------------------
  always_ff @(posedge clk) begin
    if (addr_enq) begin
      addr_q[addr_wr_ptr] <= addr_enq_val;
    end
    if (data_enq) begin
      data_q[data_wr_ptr] <= data_enq_val;
    end
  end

  // Pointers and counts; pop always takes one entry from each queue
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_wr_ptr <= '0;
      addr_rd_ptr <= '0;
      addr_cnt <= '0;
      data_wr_ptr <= '0;
      data_rd_ptr <= '0;
      data_cnt <= '0;
    end else begin
      if (addr_enq) begin
        addr_wr_ptr <= next_ptr(addr_wr_ptr);
      end
      if (data_enq) begin
        data_wr_ptr <= next_ptr(data_wr_ptr);
      end
      if (pop) begin
        addr_rd_ptr <= next_ptr(addr_rd_ptr);
        data_rd_ptr <= next_ptr(data_rd_ptr);
      end
      addr_cnt <= addr_cnt + lsq_cnt_t'(addr_enq) - lsq_cnt_t'(pop);
      data_cnt <= data_cnt + lsq_cnt_t'(data_enq) - lsq_cnt_t'(pop);
    end
  end

  // --------------------
  // Deadlock timer
  // --------------------
  // Counts while only one half of a store is waiting, saturates at the limit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dl_cnt <= '0;
    end else if (addr_empty != data_empty) begin
      if (dl_cnt < dl_cnt_t'(deadlock_timeout)) begin
        dl_cnt <= dl_cnt + 1'b1;
      end
    end else begin
      dl_cnt <= '0;
    end
  end

  assign deadlock_hit = (dl_cnt == dl_cnt_t'(deadlock_timeout));

endmodule

// ==== rtl/store_commit.sv ====
// Lowest-tag pairing arbiter driving the memory write and the store-done port
`timescale 1ns/1ps

module store_commit import ext_mem_pkg::*; (
  input  logic [st_count-1:0]       can_pair,
  input  mem_addr_t [st_count-1:0]  head_addr,
  input  mem_data_t [st_count-1:0]  head_data,
  output logic [st_count-1:0]       pop,
  output logic                      st_done_valid,
  output mem_tag_t                  st_done_tag,
  input  logic                      st_done_ready,
  output logic                      wr_en,
  output mem_addr_t                 wr_addr,
  output mem_data_t                 wr_data
);

  int   win;
  logic fire;

  // --------------------
  // Arbiter
  // --------------------
  // Descending scan leaves the lowest ready tag as the winner
  always_comb begin
    win = 0;
    for (int t = st_count - 1; t >= 0; t--) begin
      if (can_pair[t]) begin
        win = t;
      end
    end
  end

  assign st_done_valid = |can_pair;
  assign st_done_tag = mem_tag_t'(win);
  assign fire = st_done_valid && st_done_ready;

  // --------------------
  // Pop and write
  // --------------------
  always_comb begin
    pop = '0;
    if (fire) begin
      pop[win] = 1'b1;
    end
  end

  assign wr_en = fire;
  assign wr_addr = head_addr[win];
  assign wr_data = head_data[win];

endmodule

// ==== rtl/mem_error_monitor.sv ====
// Error priority encoder and sticky first-error latch
`timescale 1ns/1ps

module mem_error_monitor import ext_mem_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ld_tag_oob,
  input  logic                 st_tag_oob,
  input  logic [st_count-1:0]  deadlock_hit,
  output logic                 error_valid,
  output mem_err_e             error_code
);

  mem_err_e err_next;

  // Tag range errors outrank a store deadlock
  always_comb begin
    if (ld_tag_oob || st_tag_oob) begin
      err_next = err_tag_oob;
    end else if (|deadlock_hit) begin
      err_next = err_store_deadlock;
    end else begin
      err_next = err_none;
    end
  end

  // --------------------
  // Sticky latch
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_valid <= 1'b0;
      error_code <= err_none;
    end else if (!error_valid && err_next != err_none) begin
      // Only the first error is kept
      error_valid <= 1'b1;
      error_code <= err_next;
    end
  end

endmodule

// ==== rtl/ext_mem_top.sv ====
// External memory port top level with two load and two tagged store ports
`timescale 1ns/1ps

module ext_mem_top import ext_mem_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  // Loads
  input  logic [ld_count-1:0]       ld_req_valid,
  output logic [ld_count-1:0]       ld_req_ready,
  input  tag_req_t [ld_count-1:0]   ld_req,
  output logic [ld_count-1:0]       ld_resp_valid,
  input  logic [ld_count-1:0]       ld_resp_ready,
  output tag_data_t [ld_count-1:0]  ld_resp,
  output logic                      ld_done_valid,
  input  logic                      ld_done_ready,
  output mem_tag_t                  ld_done_tag,
  // Stores
  input  logic [st_count-1:0]       st_addr_valid,
  output logic [st_count-1:0]       st_addr_ready,
  input  tag_req_t [st_count-1:0]   st_addr,
  input  logic [st_count-1:0]       st_data_valid,
  output logic [st_count-1:0]       st_data_ready,
  input  tag_data_t [st_count-1:0]  st_data,
  output logic                      st_done_valid,
  input  logic                      st_done_ready,
  output mem_tag_t                  st_done_tag,
  // Errors
  output logic                      error_valid,
  output mem_err_e                  error_code
);

  mem_addr_t [ld_count-1:0] rd_addr;
  mem_data_t [ld_count-1:0] rd_data;
  logic                     wr_en;
  mem_addr_t                wr_addr;
  mem_data_t                wr_data;
  logic                     ld_tag_oob;
  logic                     st_tag_oob;

  // Per-tag queue signals
  logic [st_count-1:0]      addr_full;
  logic [st_count-1:0]      data_full;
  logic [st_count-1:0]      addr_enq;
  logic [st_count-1:0]      data_enq;
  mem_addr_t [st_count-1:0] addr_enq_val;
  mem_data_t [st_count-1:0] data_enq_val;
  logic [st_count-1:0]      pop;
  logic [st_count-1:0]      can_pair;
  mem_addr_t [st_count-1:0] head_addr;
  mem_data_t [st_count-1:0] head_data;
  logic [st_count-1:0]      deadlock_hit;

  mem_array mem_i (
    .clk, .rd_addr, .rd_data, .wr_en, .wr_addr, .wr_data
  );

  load_ports load_i (
    .ld_req_valid, .ld_req, .ld_req_ready, .ld_resp_valid, .ld_resp, .ld_resp_ready,
    .ld_done_valid, .ld_done_tag, .ld_done_ready, .rd_addr, .rd_data, .ld_tag_oob
  );

  // --------------------
  // Store path
  // --------------------
  store_tag_router router_i (
    .st_addr_valid, .st_addr, .st_addr_ready, .st_data_valid, .st_data, .st_data_ready,
    .addr_full, .data_full, .addr_enq, .addr_enq_val, .data_enq, .data_enq_val,
    .st_tag_oob
  );

  for (genvar t = 0; t < st_count; t++) begin : g_tag
    store_pair_queue queue_i (
      .clk, .rst_n,
      .addr_enq(addr_enq[t]), .addr_enq_val(addr_enq_val[t]),
      .data_enq(data_enq[t]), .data_enq_val(data_enq_val[t]),
      .pop(pop[t]), .addr_full(addr_full[t]), .data_full(data_full[t]),
      .can_pair(can_pair[t]), .head_addr(head_addr[t]), .head_data(head_data[t]),
      .deadlock_hit(deadlock_hit[t])
    );
  end

  store_commit commit_i (
    .can_pair, .head_addr, .head_data, .pop, .st_done_valid, .st_done_tag,
    .st_done_ready, .wr_en, .wr_addr, .wr_data
  );

  mem_error_monitor err_i (
    .clk, .rst_n, .ld_tag_oob, .st_tag_oob, .deadlock_hit, .error_valid, .error_code
  );

endmodule

// ==== verif/ext_mem_properties.sv ====
// Concurrent assertions on load handshake, store-done pairing and sticky error
`timescale 1ns/1ps

module ext_mem_properties import ext_mem_pkg::*; (
  input logic                 clk,
  input logic                 rst_n,
  input logic [ld_count-1:0]  ld_req_valid,
  input logic [ld_count-1:0]  ld_resp_valid,
  input logic [st_count-1:0]  can_pair,
  input logic                 st_done_valid,
  input logic                 error_valid
);

  // --------------------
  // Error latch
  // --------------------
  // Only a reset may clear it
  a_error_sticky: assert property (@(posedge clk) disable iff (!rst_n) !$fell(error_valid))
    else $error("error_valid fell without a reset");

  // --------------------
  // Handshakes
  // --------------------
  a_done_needs_pair: assert property (@(posedge clk) disable iff (!rst_n)
      st_done_valid |-> |can_pair)
    else $error("st_done_valid high with no tag able to pair");

  // Responses are combinational, same cycle as the request
  a_resp_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
      ld_resp_valid == ld_req_valid)
    else $error("ld_resp_valid differs from ld_req_valid");

endmodule

// ==== verif/ext_mem_tb.sv ====
// Testbench for the external memory ports with reference memory, stimulus and checks
`timescale 1ns/1ps

module ext_mem_tb import ext_mem_pkg::*; ();

  // Longest test path stays far below this, with margin for the drain waits
  localparam int max_cycles = 2000;

  typedef struct packed {
    mem_tag_t  tag;
    mem_addr_t addr;
    mem_data_t data;
  } store_exp_t;

  logic clk = 1'b0;
  logic rst_n;
  logic [ld_count-1:0]      ld_req_valid, ld_req_ready, ld_resp_valid, ld_resp_ready;
  tag_req_t [ld_count-1:0]  ld_req;
  tag_data_t [ld_count-1:0] ld_resp;
  logic                     ld_done_valid, ld_done_ready, st_done_valid, st_done_ready;
  mem_tag_t                 ld_done_tag, st_done_tag;
  logic [st_count-1:0]      st_addr_valid, st_addr_ready, st_data_valid, st_data_ready;
  tag_req_t [st_count-1:0]  st_addr;
  tag_data_t [st_count-1:0] st_data;
  logic                     error_valid;
  mem_err_e                 error_code;

  mem_data_t  ref_mem [mem_depth];
  store_exp_t exp_q [$];
  integer     seed = 32'h3e52_82c7;
  int         errors = 0;
  int         checks = 0;
  int         cycles = 0;

  ext_mem_top dut_i (.*);

  bind ext_mem_top ext_mem_properties props_i (
    .clk(clk), .rst_n(rst_n), .ld_req_valid(ld_req_valid), .ld_resp_valid(ld_resp_valid),
    .can_pair(can_pair), .st_done_valid(st_done_valid), .error_valid(error_valid)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout: run stopped after %0d cycles, %0d errors in %0d checks",
               cycles, errors, checks);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Expected load response from the reference memory
  function automatic tag_data_t expected_load(tag_req_t req);
    tag_data_t r;
    r.tag = req.tag;
    r.data = ref_mem[req.addr];
    return r;
  endfunction

  function automatic mem_data_t rand_data();
    mem_data_t r;
    r = $random(seed);
    return r;
  endfunction

  // --------------------
  // Compare process
  // --------------------
  always @(posedge clk) begin : compare
    tag_data_t  exp_resp;
    mem_tag_t   exp_tag;
    logic       exp_ready;
    store_exp_t exp_st;
    if (rst_n) begin
      for (int i = 0; i < ld_count; i++) begin
        // Response valid follows the request, request ready needs both readies
        exp_ready = ld_resp_ready[i] && ld_done_ready;
        checks++;
        assert (ld_resp_valid[i] == ld_req_valid[i] && ld_req_ready[i] == exp_ready) else begin
          errors++;
          $display("[ERROR] t=%0d ns: load port %0d resp_valid %b req_ready %b, expected %b %b",
                   $time, i, ld_resp_valid[i], ld_req_ready[i], ld_req_valid[i], exp_ready);
        end
        if (ld_resp_valid[i] && ld_resp_ready[i]) begin
          exp_resp = expected_load(ld_req[i]);
          checks++;
          assert (ld_resp[i] == exp_resp) else begin
            errors++;
            $display("[ERROR] t=%0d ns: load port %0d got %h, expected %h",
                     $time, i, ld_resp[i], exp_resp);
          end
        end
      end
      checks++;
      assert (ld_done_valid == (ld_req_valid != '0)) else begin
        errors++;
        $display("[ERROR] t=%0d ns: ld_done_valid %b with load valids %b",
                 $time, ld_done_valid, ld_req_valid);
      end
      if (ld_done_valid && ld_done_ready) begin
        exp_tag = '0;
        // Highest-numbered valid port gives the tag
        for (int i = 0; i < ld_count; i++) begin
          if (ld_req_valid[i]) exp_tag = ld_req[i].tag;
        end
        checks++;
        assert (ld_done_tag == exp_tag) else begin
          errors++;
          $display("[ERROR] t=%0d ns: load-done tag %0d, expected %0d",
                   $time, ld_done_tag, exp_tag);
        end
      end
      if (st_done_valid && st_done_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Store-done with tag %0d arrived with no store pending", st_done_tag);
        end else begin
          exp_st = exp_q.pop_front();
          checks++;
          assert (st_done_tag == exp_st.tag) else begin
            errors++;
            $display("[ERROR] t=%0d ns: store-done tag %0d, expected %0d",
                     $time, st_done_tag, exp_st.tag);
          end
          // Loads in this cycle still see the old word
          ref_mem[exp_st.addr] = exp_st.data;
        end
      end
    end
  end

  // --------------------
  // Stimulus tasks
  // --------------------
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    exp_q.delete();
    repeat (8) @(posedge clk);
    #2 rst_n = 1'b1;
  endtask

  // Address and data halves go out together and may be accepted on different edges
  task automatic do_store(input int a_port, input int d_port, input mem_tag_t tag_v,
                          input mem_addr_t addr_v, input mem_data_t data_v);
    logic a_go;
    logic d_go;
    store_exp_t st_exp;
    st_addr[a_port] = '{tag: tag_v, addr: addr_v};
    st_data[d_port] = '{tag: tag_v, data: data_v};
    st_addr_valid[a_port] = 1'b1;
    st_data_valid[d_port] = 1'b1;
    st_exp = '{tag: tag_v, addr: addr_v, data: data_v};
    exp_q.push_back(st_exp);
    while (st_addr_valid[a_port] || st_data_valid[d_port]) begin
      #1;
      a_go = st_addr_valid[a_port] && st_addr_ready[a_port];
      d_go = st_data_valid[d_port] && st_data_ready[d_port];
      next_cycle();
      if (a_go) st_addr_valid[a_port] = 1'b0;
      if (d_go) st_data_valid[d_port] = 1'b0;
    end
  endtask

  task automatic do_load(input int port, input mem_tag_t tag_v, input mem_addr_t addr_v);
    ld_req[port] = '{tag: tag_v, addr: addr_v};
    ld_req_valid[port] = 1'b1;
    next_cycle();
    ld_req_valid[port] = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) next_cycle();
  endtask

  task automatic check_bit(input logic actual, input logic expected, input string what);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("[ERROR] t=%0d ns: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin : main
    mem_addr_t addrs [8];
    mem_data_t r;
    ld_req_valid = '0;
    ld_req = '0;
    ld_resp_ready = '1;
    ld_done_ready = 1'b1;
    st_addr_valid = '0;
    st_addr = '0;
    st_data_valid = '0;
    st_data = '0;
    st_done_ready = 1'b1;
    for (int k = 0; k < 8; k++) begin
      r = rand_data();
      addrs[k] = r[addr_width-1:0];
    end
    apply_reset();

    // Same-port store with tag 0, then loads on both ports
    do_store(0, 0, 2'd0, addrs[0], rand_data());
    wait_drained();
    do_load(0, 2'd0, addrs[0]);
    do_load(1, 2'd1, addrs[0]);

    // Cross-port pairing on tag 1
    do_store(0, 1, 2'd1, addrs[1], rand_data());
    wait_drained();
    do_load(1, 2'd1, addrs[1]);

    // Both load ports at once, done tag from port 1
    ld_req[0] = '{tag: 2'd0, addr: addrs[0]};
    ld_req[1] = '{tag: 2'd1, addr: addrs[1]};
    ld_req_valid = '1;
    next_cycle();
    ld_req_valid = '0;

    // Load-done back-pressure stalls the request side
    ld_done_ready = 1'b0;
    do_load(0, 2'd0, addrs[0]);
    ld_done_ready = 1'b1;

    // Back-pressure fills tag 0, then drains in order
    st_done_ready = 1'b0;
    for (int k = 0; k < lsq_depth; k++) begin
      st_addr[0] = '{tag: 2'd0, addr: addrs[2 + k]};
      #1;
      check_bit(st_addr_ready[0], 1'b1, "st_addr_ready[0] before full");
      do_store(0, 0, 2'd0, addrs[2 + k], rand_data());
    end
    #1;
    check_bit(st_addr_ready[0], 1'b0, "st_addr_ready[0] when full");
    check_bit(st_data_ready[0], 1'b0, "st_data_ready[0] when full");
    next_cycle();
    st_done_ready = 1'b1;
    wait_drained();
    for (int k = 0; k < lsq_depth; k++) do_load(k % 2, 2'd0, addrs[2 + k]);
    check_bit(error_valid, 1'b0, "error_valid after normal traffic");

    // Lone store address runs into the deadlock timer
    apply_reset();
    st_addr[0] = '{tag: 2'd1, addr: addrs[6]};
    st_addr_valid[0] = 1'b1;
    #1;
    check_bit(st_addr_ready[0], 1'b1, "st_addr_ready[0] after reset");
    next_cycle();
    st_addr_valid[0] = 1'b0;
    for (int k = 1; k < deadlock_timeout; k++) begin
      next_cycle();
      check_bit(error_valid, 1'b0, "error_valid before deadlock limit");
    end
    repeat (3) next_cycle();
    check_bit(error_valid, 1'b1, "error_valid after deadlock limit");
    check_bit(error_code == err_store_deadlock, 1'b1, "deadlock error code match");

    // Load tag out of range
    apply_reset();
    check_bit(error_valid, 1'b0, "error_valid after reset");
    do_load(0, 2'd3, addrs[0]);
    check_bit(error_valid, 1'b1, "error_valid after bad load tag");
    check_bit(error_code == err_tag_oob, 1'b1, "tag range error code match");

    $display("Run complete: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== ext_mem.f ====
rtl/ext_mem_pkg.sv
rtl/mem_array.sv
rtl/load_ports.sv
rtl/store_tag_router.sv
rtl/store_pair_queue.sv
rtl/store_commit.sv
rtl/mem_error_monitor.sv
rtl/ext_mem_top.sv
verif/ext_mem_properties.sv
verif/ext_mem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the ext_mem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module ext_mem_tb -f ext_mem.f -o ext_mem_sim; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/ext_mem_sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" <<< "$output"; then
  exit 0
fi
exit 1
